//--- rtl/memPkg.sv
`default_nettype none

package memPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;    // Data or address word
    typedef logic [STRB_W-1:0] strobe_t;  // One enable per byte lane
    typedef logic [1:0]        msize_t;
    typedef logic [4:0]        excCode_t;
    typedef logic [4:0]        regIdx_t;

    ////////////////////////////////////////////////////////////////////////////
    // Codes
    ////////////////////////////////////////////////////////////////////////////

    localparam msize_t MSIZE1 = 2'd0;     // Byte
    localparam msize_t MSIZE2 = 2'd1;     // Half
    localparam msize_t MSIZE4 = 2'd2;     // Word

    localparam excCode_t EXC_NONE = 5'd0;
    localparam excCode_t EXC_ADEL = 5'd4; // Address error on load
    localparam excCode_t EXC_ADES = 5'd5; // Address error on store

    // kseg0 and kseg1 share address bits 31..30
    localparam logic [1:0] KSEG_TOP = 2'b10;

    ////////////////////////////////////////////////////////////////////////////
    // Slot and bus structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   memToReg;                 // Load
        logic   memWrite;                 // Store
        logic   signedLoad;
        logic   regWrite;
        msize_t msize;
    } memCtl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regIdx_t  rdst;
        memCtl_t  ctl;
        word_t    aluOut;                 // Virtual address for loads and stores
        word_t    srcb;                   // Store source
        excCode_t excIn;                  // Cause raised by an earlier stage
    } slot_t;

    typedef struct packed {
        word_t   addr;                    // Physical byte address
        word_t   data;
        strobe_t strobe;
        msize_t  size;
        logic    write;
        logic    uncached;
    } busReq_t;

    typedef struct packed {
        busReq_t  busReq;
        logic     misaligned;
        excCode_t excCode;
    } laneInfo_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        regIdx_t  rdst;
        logic     regWrite;
        word_t    result;
        excCode_t excCode;
        word_t    badVAddr;
    } slotOut_t;

    typedef enum logic [2:0] {
        IDLE,
        LANE1,
        LANE0,
        DONE,
        RELEASE
    } accState_e;

endpackage

`default_nettype wire

//--- rtl/addrCheck.sv
`timescale 1ns/10ps
`default_nettype none

module addrCheck (
    input  wire memPkg::slot_t     slot,
    output memPkg::laneInfo_t      info
);

    memPkg::word_t    vaddr;
    memPkg::word_t    paddr;
    memPkg::word_t    wdata;
    memPkg::strobe_t  strobe;
    memPkg::excCode_t excCode;
    logic             isLoad;
    logic             isStore;
    logic             misaligned;
    logic             uncached;

    assign vaddr   = slot.aluOut;
    assign isLoad  = slot.ctl.memToReg;
    assign isStore = slot.ctl.memWrite;

    always_comb begin
        case (slot.ctl.msize)
            memPkg::MSIZE2: misaligned = vaddr[0];
            memPkg::MSIZE4: misaligned = vaddr[1:0] != 2'b00;
            default:        misaligned = 1'b0;
        endcase
        if (!(isLoad || isStore)) begin
            misaligned = 1'b0;            // Only memory ops can fault here
        end
    end

    always_comb begin
        if (slot.excIn != memPkg::EXC_NONE) begin
            excCode = slot.excIn;         // Earlier cause wins
        end else if (misaligned) begin
            excCode = isStore ? memPkg::EXC_ADES : memPkg::EXC_ADEL;
        end else begin
            excCode = memPkg::EXC_NONE;
        end
    end

    // Fixed segment mapping, no TLB
    always_comb begin
        paddr    = vaddr;
        uncached = 1'b0;
        if (vaddr[31:30] == memPkg::KSEG_TOP) begin
            paddr    = {3'b000, vaddr[28:0]};
            uncached = vaddr[29];         // kseg1
        end
    end

    always_comb begin
        case (slot.ctl.msize)
            memPkg::MSIZE1: begin
                wdata  = {4{slot.srcb[7:0]}};
                strobe = 4'b0001 << vaddr[1:0];
            end
            memPkg::MSIZE2: begin
                wdata  = {2{slot.srcb[15:0]}};
                strobe = vaddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata  = slot.srcb;
                strobe = 4'b1111;
            end
        endcase
    end

    always_comb begin
        info                 = '0;
        info.busReq.addr     = paddr;
        info.busReq.data     = wdata;
        info.busReq.strobe   = isStore ? strobe : '0;
        info.busReq.size     = slot.ctl.msize;
        info.busReq.write    = isStore;
        info.busReq.uncached = uncached;
        info.misaligned      = misaligned;
        info.excCode         = excCode;
    end

    assertMisalignExc: assert final (!info.misaligned || info.excCode != memPkg::EXC_NONE)
        else $error("misaligned lane reports no exception");

endmodule

`default_nettype wire

//--- rtl/memAccess.sv
`timescale 1ns/10ps
`default_nettype none

module memAccess (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                inReq,
    output logic                     inAck,
    input  wire memPkg::slot_t [1:0] slotsIn,
    output memPkg::slot_t [1:0]      slotsCap,
    input  wire memPkg::laneInfo_t   info1,
    input  wire memPkg::laneInfo_t   info0,
    output logic                     busReq,
    output memPkg::busReq_t          busPkt,
    input  wire logic                busAck,
    input  wire memPkg::word_t       busRData,
    output memPkg::word_t            loadData1,
    output memPkg::word_t            loadData0,
    output logic                     outReq,
    input  wire logic                outAck
);

    memPkg::accState_e state;
    memPkg::accState_e laneNext;
    memPkg::busReq_t   curPkt;
    logic              lane1Exc;
    logic              need1;
    logic              need0;
    logic              laneActive;
    logic              curNeed;
    logic              busDone;       // Current lane got its ack, waiting for it to fall
    logic              capture;
    logic              raise;
    logic              advance;

    function automatic logic needsBus(input memPkg::slot_t s, input memPkg::laneInfo_t li);
        return s.valid && (s.ctl.memToReg || s.ctl.memWrite) && !li.misaligned &&
               s.excIn == memPkg::EXC_NONE;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Lane selection
    ////////////////////////////////////////////////////////////////////////////

    assign lane1Exc = slotsCap[1].valid && info1.excCode != memPkg::EXC_NONE;
    assign need1    = needsBus(slotsCap[1], info1);
    assign need0    = needsBus(slotsCap[0], info0) && !lane1Exc;  // Older lane squashes

    assign laneActive = state == memPkg::LANE1 || state == memPkg::LANE0;
    assign curNeed    = (state == memPkg::LANE1) ? need1 : need0;
    assign curPkt     = (state == memPkg::LANE1) ? info1.busReq : info0.busReq;
    assign laneNext   = (state == memPkg::LANE1) ? memPkg::LANE0 : memPkg::DONE;

    assign capture = state == memPkg::IDLE && inReq && !inAck;
    assign raise   = laneActive && curNeed && !busReq && !busDone;
    assign advance = laneActive && (!curNeed || (busDone && !busAck));

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= memPkg::IDLE;
            inAck   <= 1'b0;
            busReq  <= 1'b0;
            busDone <= 1'b0;
            outReq  <= 1'b0;
        end else begin
            if (capture) begin
                inAck <= 1'b1;
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;              // Input release
            end

            if (raise) begin
                busReq <= 1'b1;
            end else if (busReq && busAck) begin
                busReq  <= 1'b0;
                busDone <= 1'b1;
            end else if (advance) begin
                busDone <= 1'b0;
            end

            case (state)
                memPkg::IDLE: begin
                    if (capture) begin
                        state <= memPkg::LANE1;
                    end
                end
                memPkg::LANE1, memPkg::LANE0: begin
                    if (advance) begin
                        state <= laneNext;
                        if (laneNext == memPkg::DONE) begin
                            outReq <= 1'b1;
                        end
                    end
                end
                memPkg::DONE: begin
                    if (outAck) begin
                        outReq <= 1'b0;
                        state  <= memPkg::RELEASE;
                    end
                end
                memPkg::RELEASE: begin
                    if (!outAck) begin
                        state <= memPkg::IDLE;
                    end
                end
                default: state <= memPkg::IDLE;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (capture) begin
            slotsCap <= slotsIn;
        end
        if (raise) begin
            busPkt <= curPkt;
        end
        if (busReq && busAck && state == memPkg::LANE1) begin
            loadData1 <= busRData;
        end
        if (busReq && busAck && state == memPkg::LANE0) begin
            loadData0 <= busRData;
        end
    end

    assertPktStable: assert property (@(posedge clk) disable iff (!rstN)
        busReq ##1 busReq |-> $stable(busPkt));

    assertNoBusIdle: assert property (@(posedge clk) disable iff (!rstN)
        state == memPkg::IDLE |-> !busReq);

endmodule

`default_nettype wire

//--- rtl/slotCommit.sv
`timescale 1ns/10ps
`default_nettype none

module slotCommit (
    input  wire memPkg::slot_t [1:0] slotsCap,
    input  wire memPkg::laneInfo_t   info1,
    input  wire memPkg::laneInfo_t   info0,
    input  wire memPkg::word_t       loadData1,
    input  wire memPkg::word_t       loadData0,
    output memPkg::slotOut_t [1:0]   slotsOut,
    output logic                     excM
);

    memPkg::laneInfo_t [1:0] info;
    memPkg::word_t [1:0]     loadData;
    logic [1:0]              hasExc;

    assign info     = {info1, info0};
    assign loadData = {loadData1, loadData0};

    ////////////////////////////////////////////////////////////////////////////
    // Load extraction
    ////////////////////////////////////////////////////////////////////////////

    function automatic memPkg::word_t extractLoad(
        input memPkg::word_t   raw,
        input logic [1:0]      ofs,
        input memPkg::memCtl_t ctl
    );
        logic [7:0]    b;
        logic [15:0]   h;
        memPkg::word_t r;
        b = raw[{ofs, 3'b000} +: 8];
        h = ofs[1] ? raw[31:16] : raw[15:0];
        case (ctl.msize)
            memPkg::MSIZE1: r = {{24{ctl.signedLoad & b[7]}}, b};
            memPkg::MSIZE2: r = {{16{ctl.signedLoad & h[15]}}, h};
            default:        r = raw;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Commit
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hasExc[i] = slotsCap[i].valid && info[i].excCode != memPkg::EXC_NONE;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slotsOut[i].valid    = slotsCap[i].valid;
            slotsOut[i].pc       = slotsCap[i].pc;
            slotsOut[i].rdst     = slotsCap[i].rdst;
            slotsOut[i].regWrite = slotsCap[i].valid && slotsCap[i].ctl.regWrite &&
                                   !hasExc[i];
            if (slotsCap[i].ctl.memToReg) begin
                slotsOut[i].result = extractLoad(loadData[i], slotsCap[i].aluOut[1:0],
                                                 slotsCap[i].ctl);
            end else begin
                slotsOut[i].result = slotsCap[i].aluOut;
            end
            slotsOut[i].excCode  = info[i].excCode;
            slotsOut[i].badVAddr = hasExc[i] ? slotsCap[i].aluOut : '0;
        end

        if (hasExc[1]) begin              // Younger lane never commits
            slotsOut[0].valid    = 1'b0;
            slotsOut[0].regWrite = 1'b0;
        end
    end

    assign excM = |hasExc;

endmodule

`default_nettype wire

//--- rtl/memStage.sv
`timescale 1ns/10ps
`default_nettype none

module memStage (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                inReq,
    output logic                     inAck,
    input  wire memPkg::slot_t [1:0] slotsIn,
    output logic                     busReq,
    output memPkg::busReq_t          busPkt,
    input  wire logic                busAck,
    input  wire memPkg::word_t       busRData,
    output logic                     outReq,
    input  wire logic                outAck,
    output memPkg::slotOut_t [1:0]   slotsOut,
    output logic                     excM
);

    memPkg::slot_t [1:0] slotsCap;
    memPkg::laneInfo_t   info1;
    memPkg::laneInfo_t   info0;
    memPkg::word_t       loadData1;
    memPkg::word_t       loadData0;

    memAccess uAccess (
        .clk       (clk),
        .rstN      (rstN),
        .inReq     (inReq),
        .inAck     (inAck),
        .slotsIn   (slotsIn),
        .slotsCap  (slotsCap),
        .info1     (info1),
        .info0     (info0),
        .busReq    (busReq),
        .busPkt    (busPkt),
        .busAck    (busAck),
        .busRData  (busRData),
        .loadData1 (loadData1),
        .loadData0 (loadData0),
        .outReq    (outReq),
        .outAck    (outAck)
    );

    addrCheck uCheck1 (.slot(slotsCap[1]), .info(info1));   // Older lane
    addrCheck uCheck0 (.slot(slotsCap[0]), .info(info0));

    slotCommit uCommit (
        .slotsCap  (slotsCap),
        .info1     (info1),
        .info0     (info0),
        .loadData1 (loadData1),
        .loadData0 (loadData0),
        .slotsOut  (slotsOut),
        .excM      (excM)
    );

    // Result pair must hold while downstream has not acknowledged
    assertOutStable: assert property (@(posedge clk) disable iff (!rstN)
        outReq ##1 outReq |-> $stable(slotsOut) && $stable(excM));

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;           // 20 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;                     // Released on an edge like any other input
    end

endmodule

`default_nettype wire

//--- tests/dataMemModel.sv
`timescale 1ns/10ps
`default_nettype none

module dataMemModel (
    input  wire logic            clk,
    input  wire logic            busReq,
    input  wire memPkg::busReq_t busPkt,
    output logic                 busAck,
    output memPkg::word_t        busRData
);

    memPkg::word_t mem [memPkg::word_t];  // Written words by word address
    integer        seed = 32'hde19;

    // Untouched words hold their address XOR the fill pattern
    function automatic memPkg::word_t readWord(input memPkg::word_t addr);
        memPkg::word_t wa;
        wa = {addr[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'h5a5a_0000;
    endfunction

    task automatic writeWord(input memPkg::busReq_t pkt);
        memPkg::word_t w;
        w = readWord(pkt.addr);
        for (int b = 0; b < 4; b++) begin
            if (pkt.strobe[b]) begin
                w[8*b +: 8] = pkt.data[8*b +: 8];
            end
        end
        mem[{pkt.addr[31:2], 2'b00}] = w;
    endtask

    initial begin : respond
        int delay;
        busAck   = 1'b0;
        busRData = '0;
        forever begin
            @(posedge clk);
            if (busReq && !busAck) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                busRData <= readWord(busPkt.addr);
                if (busPkt.write) begin
                    writeWord(busPkt);
                end
                busAck <= 1'b1;
                do @(posedge clk); while (busReq);
                busAck <= 1'b0;           // Release phase
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/memStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module memStageTb;

    typedef struct packed {
        memPkg::slot_t [1:0]    slots;
        memPkg::slotOut_t [1:0] exp;
        logic                   excM;
    } vector_t;

    logic                   clk;
    logic                   rstN;
    logic                   inReq;
    logic                   inAck;
    memPkg::slot_t [1:0]    slotsIn;
    logic                   busReq;
    memPkg::busReq_t        busPkt;
    logic                   busAck;
    memPkg::word_t          busRData;
    logic                   outReq;
    logic                   outAck;
    memPkg::slotOut_t [1:0] slotsOut;
    logic                   excM;
    vector_t                vectors [$];
    logic                   tableReady = 1'b0;
    integer                 seed = 32'hde19;
    int                     curIdx = 0;
    int                     busCount = 0;
    logic                   busReqPrev = 1'b0;

    clockGen uClk (.clk(clk), .rstN(rstN));

    dataMemModel uMem (
        .clk      (clk),
        .busReq   (busReq),
        .busPkt   (busPkt),
        .busAck   (busAck),
        .busRData (busRData)
    );

    memStage dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .inReq    (inReq),
        .inAck    (inAck),
        .slotsIn  (slotsIn),
        .busReq   (busReq),
        .busPkt   (busPkt),
        .busAck   (busAck),
        .busRData (busRData),
        .outReq   (outReq),
        .outAck   (outAck),
        .slotsOut (slotsOut),
        .excM     (excM)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Slot and expected result builders
    ////////////////////////////////////////////////////////////////////////////

    function automatic memPkg::slot_t loadSlot(input memPkg::regIdx_t rd,
                                               input memPkg::msize_t sz,
                                               input logic sgn, input memPkg::word_t va);
        memPkg::slot_t s;
        s                = '0;
        s.valid          = 1'b1;
        s.rdst           = rd;
        s.ctl.memToReg   = 1'b1;
        s.ctl.regWrite   = 1'b1;
        s.ctl.signedLoad = sgn;
        s.ctl.msize      = sz;
        s.aluOut         = va;
        return s;
    endfunction

    function automatic memPkg::slot_t storeSlot(input memPkg::msize_t sz,
                                                input memPkg::word_t va,
                                                input memPkg::word_t data);
        memPkg::slot_t s;
        s              = '0;
        s.valid        = 1'b1;
        s.ctl.memWrite = 1'b1;
        s.ctl.msize    = sz;
        s.aluOut       = va;
        s.srcb         = data;
        return s;
    endfunction

    function automatic memPkg::slot_t aluSlot(input memPkg::regIdx_t rd,
                                              input memPkg::word_t value);
        memPkg::slot_t s;
        s              = '0;
        s.valid        = 1'b1;
        s.rdst         = rd;
        s.ctl.regWrite = 1'b1;
        s.ctl.msize    = memPkg::MSIZE4;
        s.aluOut       = value;
        return s;
    endfunction

    function automatic memPkg::slotOut_t okOut(input memPkg::slot_t s,
                                               input memPkg::word_t res);
        memPkg::slotOut_t o;
        o          = '0;
        o.valid    = s.valid;
        o.rdst     = s.rdst;
        o.regWrite = s.ctl.regWrite;
        o.result   = res;
        o.excCode  = memPkg::EXC_NONE;
        return o;
    endfunction

    function automatic memPkg::slotOut_t faultOut(input memPkg::slot_t s,
                                                  input memPkg::excCode_t code);
        memPkg::slotOut_t o;
        o          = '0;
        o.valid    = 1'b1;
        o.rdst     = s.rdst;
        o.excCode  = code;
        o.badVAddr = s.aluOut;            // Result is not compared for a faulting lane
        return o;
    endfunction

    function automatic memPkg::slotOut_t squashOut(input memPkg::slot_t s);
        memPkg::slotOut_t o;
        o          = okOut(s, s.aluOut);
        o.valid    = 1'b0;
        o.regWrite = 1'b0;
        return o;
    endfunction

    task automatic addVector(input memPkg::slot_t s1, input memPkg::slot_t s0,
                             input memPkg::slotOut_t e1, input memPkg::slotOut_t e0,
                             input logic exc);
        vector_t v;
        v.slots[1]  = s1;
        v.slots[0]  = s0;
        v.exp[1]    = e1;
        v.exp[0]    = e0;
        v.excM      = exc;
        v.slots[1].pc = 32'h0040_0000 + 8 * vectors.size();
        v.slots[0].pc = v.slots[1].pc + 4;
        v.exp[1].pc   = v.slots[1].pc;
        v.exp[0].pc   = v.slots[0].pc;
        vectors.push_back(v);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic fillTable();
        memPkg::slot_t s1;
        memPkg::slot_t s0;
        // Aligned kseg0 loads, word 0x81f0 reads 5a5a81f0
        s1 = loadSlot(5'd2, memPkg::MSIZE4, 1'b0, 32'h8000_81f0);
        s0 = loadSlot(5'd3, memPkg::MSIZE2, 1'b1, 32'h8000_81f0);
        addVector(s1, s0, okOut(s1, 32'h5a5a_81f0), okOut(s0, 32'hffff_81f0), 1'b0);
        s1 = loadSlot(5'd4, memPkg::MSIZE2, 1'b0, 32'h8000_81f0);
        s0 = loadSlot(5'd5, memPkg::MSIZE1, 1'b1, 32'h8000_81f1);
        addVector(s1, s0, okOut(s1, 32'h0000_81f0), okOut(s0, 32'hffff_ff81), 1'b0);
        s1 = loadSlot(5'd6, memPkg::MSIZE1, 1'b0, 32'h8000_81f0);
        s0 = loadSlot(5'd7, memPkg::MSIZE2, 1'b1, 32'h8000_81f2);
        addVector(s1, s0, okOut(s1, 32'h0000_00f0), okOut(s0, 32'h0000_5a5a), 1'b0);
        // Store then load, bytes outside the strobe keep the fill
        s1 = storeSlot(memPkg::MSIZE1, 32'h8000_0202, 32'h1234_563c);
        s0 = loadSlot(5'd8, memPkg::MSIZE4, 1'b0, 32'h8000_0200);
        addVector(s1, s0, okOut(s1, s1.aluOut), okOut(s0, 32'h5a3c_0200), 1'b0);
        s1 = storeSlot(memPkg::MSIZE2, 32'h8000_0206, 32'habcd_beef);
        s0 = loadSlot(5'd9, memPkg::MSIZE2, 1'b1, 32'h8000_0206);
        addVector(s1, s0, okOut(s1, s1.aluOut), okOut(s0, 32'hffff_beef), 1'b0);
        s1 = storeSlot(memPkg::MSIZE4, 32'h8000_0208, 32'hcafe_f00d);
        s0 = loadSlot(5'd10, memPkg::MSIZE4, 1'b0, 32'ha000_0208);   // kseg1 alias
        addVector(s1, s0, okOut(s1, s1.aluOut), okOut(s0, 32'hcafe_f00d), 1'b0);
        // Faults only in lane 0
        s1 = aluSlot(5'd11, 32'h1357_9bdf);
        s0 = loadSlot(5'd12, memPkg::MSIZE2, 1'b1, 32'h8000_0301);
        addVector(s1, s0, okOut(s1, s1.aluOut), faultOut(s0, memPkg::EXC_ADEL), 1'b1);
        s1 = aluSlot(5'd13, 32'h2468_ace0);
        s0 = storeSlot(memPkg::MSIZE4, 32'h8000_0306, 32'hdead_beef);
        addVector(s1, s0, okOut(s1, s1.aluOut), faultOut(s0, memPkg::EXC_ADES), 1'b1);
        // Lane 1 faults squash the lane 0 store
        s1 = loadSlot(5'd14, memPkg::MSIZE4, 1'b0, 32'h8000_0311);
        s0 = storeSlot(memPkg::MSIZE4, 32'h8000_0400, 32'h1122_3344);
        addVector(s1, s0, faultOut(s1, memPkg::EXC_ADEL), squashOut(s0), 1'b1);
        s1 = aluSlot(5'd15, 32'h0000_0777);
        s1.excIn = 5'd12;
        s0 = storeSlot(memPkg::MSIZE4, 32'h8000_0404, 32'h5566_7788);
        addVector(s1, s0, faultOut(s1, 5'd12), squashOut(s0), 1'b1);
        // Memory untouched by the faulting and squashed stores
        s1 = loadSlot(5'd16, memPkg::MSIZE4, 1'b0, 32'h8000_0304);
        s0 = loadSlot(5'd17, memPkg::MSIZE4, 1'b0, 32'h8000_0400);
        addVector(s1, s0, okOut(s1, 32'h5a5a_0304), okOut(s0, 32'h5a5a_0400), 1'b0);
        s1 = loadSlot(5'd18, memPkg::MSIZE4, 1'b0, 32'h8000_0404);
        s0 = loadSlot(5'd19, memPkg::MSIZE2, 1'b1, 32'ha000_81f0);
        addVector(s1, s0, okOut(s1, 32'h5a5a_0404), okOut(s0, 32'hffff_81f0), 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkSlotOut(input memPkg::slotOut_t got, input memPkg::slotOut_t exp,
                                input int idx, input int lane);
        logic bad;
        bad = got.valid !== exp.valid || got.pc !== exp.pc || got.rdst !== exp.rdst ||
              got.regWrite !== exp.regWrite || got.excCode !== exp.excCode ||
              got.badVAddr !== exp.badVAddr;
        if (exp.excCode == memPkg::EXC_NONE && got.result !== exp.result) begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("FAILED at %0t: vector %0d lane %0d slot output %h, expected %h",
                     $time, idx, lane, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "slot output mismatch");
        end
    endtask

    task automatic checkExc(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            $display("FAILED at %0t: vector %0d excM %b, expected %b", $time, idx, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "excM mismatch");
        end
    endtask

    // A lane reaches the bus when it is a load or store that commits without a fault
    function automatic logic usesBus(input vector_t v, input int lane);
        return (v.slots[lane].ctl.memToReg || v.slots[lane].ctl.memWrite) &&
               v.exp[lane].valid && v.exp[lane].excCode == memPkg::EXC_NONE;
    endfunction

    task automatic checkBusPkt(input memPkg::busReq_t got, input memPkg::slot_t s,
                               input int idx, input int lane);
        memPkg::word_t va;
        memPkg::word_t pa;
        logic          unc;
        va  = s.aluOut;
        pa  = va;
        unc = va[31:29] == 3'b101;
        if (va[31:30] == 2'b10) begin
            pa[31:29] = 3'b000;
        end
        if (got.addr !== pa || got.uncached !== unc || got.write !== s.ctl.memWrite) begin
            $display("FAILED at %0t: vector %0d lane %0d bus addr %h uncached %b write %b",
                     $time, idx, lane, got.addr, got.uncached, got.write);
            $display("STATUS: FAIL");
            $fatal(1, "bus packet mismatch");
        end
    endtask

    // Bus monitor, lane 1 goes first when it uses the bus
    always @(posedge clk) begin
        int lane;
        busReqPrev <= busReq;
        if (busReq && !busReqPrev) begin
            lane = (busCount == 0 && usesBus(vectors[curIdx], 1)) ? 1 : 0;
            if (busCount > 1 || !usesBus(vectors[curIdx], lane)) begin
                $display("Unexpected bus request during vector %0d", curIdx);
                $display("STATUS: FAIL");
                $fatal(1, "unexpected bus request");
            end
            checkBusPkt(busPkt, vectors[curIdx].slots[lane], curIdx, lane);
            busCount = busCount + 1;
        end
    end

    task automatic runVector(input int idx);
        int delay;
        @(posedge clk);
        curIdx   = idx;
        busCount = 0;
        slotsIn <= vectors[idx].slots;
        inReq   <= 1'b1;
        do @(posedge clk); while (!inAck);
        inReq <= 1'b0;
        do @(posedge clk); while (!outReq);
        checkSlotOut(slotsOut[1], vectors[idx].exp[1], idx, 1);
        checkSlotOut(slotsOut[0], vectors[idx].exp[0], idx, 0);
        checkExc(excM, vectors[idx].excM, idx);
        delay = $unsigned($random(seed)) % 5;   // Downstream back-pressure
        repeat (delay) @(posedge clk);
        outAck <= 1'b1;
        do @(posedge clk); while (outReq);
        outAck <= 1'b0;
    endtask

    initial begin
        inReq   = 1'b0;
        outAck  = 1'b0;
        slotsIn = '0;
        fillTable();
        tableReady = 1'b1;
        @(posedge rstN);
        for (int i = 0; i < vectors.size(); i++) begin
            runVector(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (tableReady);
        repeat (vectors.size() * 200) @(posedge clk);
        $display("Timeout: the stage did not complete %0d slot pairs in time", vectors.size());
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/memPkg.sv
rtl/addrCheck.sv
rtl/memAccess.sv
rtl/slotCommit.sv
rtl/memStage.sv
tests/clockGen.sv
tests/dataMemModel.sv
tests/memStageTb.sv

//--- Bender.yml
package:
  name: memStage

sources:
  - rtl/memPkg.sv
  - rtl/addrCheck.sv
  - rtl/memAccess.sv
  - rtl/slotCommit.sv
  - rtl/memStage.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/dataMemModel.sv
      - tests/memStageTb.sv

# Top levels: memStage for the design, memStageTb for simulation
# The plain file order matches filelist.f
# Test sources need the test target enabled
